/* Bender.yml */
package:
  name: red_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/red_pkg.sv
      - common/red_beat_if.sv
      - red_tree/red_tree.sv
      - design/red_accum.sv
      - design/red_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - dv/tb_clk_gen.sv
      - dv/red_tb.sv

/* common/red_beat_if.sv */
interface red_beat_if;
    import red_pkg::*;

    logic    valid;
    logic    ready;
    red_op_t op;
    elem_t   partial;

    // tree side
    modport src (
        output valid,
        output op,
        output partial,
        input  ready
    );

    // accumulator side
    modport dst (
        input  valid,
        input  op,
        input  partial,
        output ready
    );

endinterface

/* common/red_pkg.sv */
`include "red_settings.svh"

package red_pkg;

    // ----------------------------------------
    // data types
    // ----------------------------------------

    typedef logic [`RED_ELEM_W-1:0] elem_t;

    // lane 0 sits in the low bits
    typedef logic [`RED_ELEMS_PER_BEAT*`RED_ELEM_W-1:0] beat_data_t;

    // beat index within a vector
    typedef logic [$clog2(`RED_BEATS_PER_VEC)-1:0] beat_cnt_t;

    // register levels of the pairwise tree
    localparam int TREE_LEVELS = $clog2(`RED_ELEMS_PER_BEAT);

    // ----------------------------------------
    // op codes
    // ----------------------------------------

    typedef logic [1:0] red_op_t;

    localparam red_op_t OP_UI_SUM = 2'd0;
    localparam red_op_t OP_UI_MAX = 2'd1;
    localparam red_op_t OP_SI_SUM = 2'd2;
    localparam red_op_t OP_SI_MAX = 2'd3;

    typedef enum logic {
        ACC_COLLECT,
        ACC_HOLD
    } acc_state_e;

    // one reduction step on two elements
    // signed and unsigned sums share the same wrapping adder
    function automatic elem_t red_combine(
        input red_op_t op,
        input elem_t   a,
        input elem_t   b
    );
        elem_t res;
        case (op)
            OP_UI_SUM,
            OP_SI_SUM: res = a + b;
            OP_UI_MAX: res = (a > b) ? a : b;
            default:   res = ($signed(a) > $signed(b)) ? a : b;
        endcase
        return res;
    endfunction

endpackage

/* common/red_settings.svh */
`ifndef RED_SETTINGS_SVH
`define RED_SETTINGS_SVH

// ----------------------------------------
// reduction unit sizing
// ----------------------------------------

// element width in bits
`define RED_ELEM_W          16

// elements per input beat
// must be a power of two for the pairwise tree
`define RED_ELEMS_PER_BEAT  8

// beats that make up one vector
`define RED_BEATS_PER_VEC   4

`endif

/* design/red_accum.sv */
`include "red_settings.svh"

module red_accum (
    input  logic           clk,
    input  logic           rst_n,

    // reduced beats from the tree
    red_beat_if.dst        beat_i,

    // finished scalar per vector
    output logic           res_valid_o,
    input  logic           res_ready_i,
    output red_pkg::elem_t res_elem_o
);
    import red_pkg::*;

    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(`RED_BEATS_PER_VEC - 1);

    acc_state_e state_q;
    beat_cnt_t  beat_cnt_q;
    elem_t      acc_q;
    elem_t      acc_d;
    red_op_t    op_q;
    logic       beat_xfer;
    logic       last_beat;

    // only take beats while collecting
    assign beat_i.ready = (state_q == ACC_COLLECT);
    assign beat_xfer    = beat_i.valid && beat_i.ready;
    assign last_beat    = (beat_cnt_q == LAST_BEAT);

    // first beat of a vector loads the running value
    always_comb begin
        if (beat_cnt_q == '0) begin
            acc_d = beat_i.partial;
        end else begin
            acc_d = red_combine(beat_i.op, acc_q, beat_i.partial);
        end
    end

    // ----------------------------------------
    // FSM and beat counter
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= ACC_COLLECT;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                ACC_COLLECT: begin
                    if (beat_xfer) begin
                        if (last_beat) begin
                            beat_cnt_q <= '0;
                            state_q    <= ACC_HOLD;
                        end else begin
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                        end
                    end
                end
                ACC_HOLD: begin
                    // back to collecting once the result is taken
                    if (res_ready_i) begin
                        state_q <= ACC_COLLECT;
                    end
                end
                default: state_q <= ACC_COLLECT;
            endcase
        end
    end

    // running value and op of the vector in progress
    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            acc_q <= acc_d;
            op_q  <= beat_i.op;
        end
    end

    assign res_valid_o = (state_q == ACC_HOLD);
    assign res_elem_o  = acc_q;

    // op may not switch in the middle of a vector
    a_op_const: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_xfer && (beat_cnt_q != '0) |-> (beat_i.op == op_q)
    ) else $error("red_accum: op changed within a vector");

    // result stays up and unchanged until accepted
    a_res_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_elem_o)
    ) else $error("red_accum: result dropped before acceptance");

endmodule

/* design/red_top.sv */
`include "red_settings.svh"

module red_top (
    input  logic                clk,
    input  logic                rst_n,

    // ----------------------------------------
    // beat input
    // ----------------------------------------
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  red_pkg::red_op_t    in_op_i,
    input  red_pkg::beat_data_t in_data_i,

    // ----------------------------------------
    // vector result
    // ----------------------------------------
    output logic                res_valid_o,
    input  logic                res_ready_i,
    output red_pkg::beat_data_t res_data_o
);
    import red_pkg::*;

    // scalar result of the accumulator
    elem_t res_elem;

    // tree to accumulator
    red_beat_if beat_if ();

    red_tree u_tree (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_op_i    (in_op_i),
        .in_data_i  (in_data_i),
        .beat_o     (beat_if.src)
    );

    red_accum u_accum (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat_i      (beat_if.dst),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_elem_o  (res_elem)
    );

    // broadcast the scalar into every lane
    assign res_data_o = {`RED_ELEMS_PER_BEAT{res_elem}};

endmodule

/* dv/red_tb.sv */
`include "red_settings.svh"

module red_tb;
    import red_pkg::*;

    localparam int EW      = `RED_ELEM_W;
    localparam int LANES   = `RED_ELEMS_PER_BEAT;
    localparam int BEATS   = `RED_BEATS_PER_VEC;
    localparam int NELEM   = LANES * BEATS;
    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    red_op_t    in_op;
    beat_data_t in_data;
    logic       res_valid;
    logic       res_ready;
    beat_data_t res_data;

    // expected scalars in send order, scalars seen at the output
    elem_t exp_q [$];
    elem_t got_q [$];

    // vector under construction
    elem_t vec_buf [NELEM];

    logic  rand_ready;
    int    max_gap;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    red_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .in_op_i     (in_op),
        .in_data_i   (in_data),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready),
        .res_data_o  (res_data)
    );

    // ----------------------------------------
    // reporting
    // ----------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at time %0t: %s (got %0h, expected %0h)",
                               $time, msg, got, exp));
        end
    endtask

    // ----------------------------------------
    // model and stimulus
    // ----------------------------------------

    // fold all elements in beat order
    function automatic elem_t model_reduce(input red_op_t op);
        elem_t acc;
        acc = vec_buf[0];
        for (int i = 1; i < NELEM; i++) begin
            acc = red_combine(op, acc, vec_buf[i]);
        end
        return acc;
    endfunction

    // kind 0 random, 1 top bit always set, 2 random with both signs present
    task automatic fill_vec(input int kind);
        for (int i = 0; i < NELEM; i++) begin
            if (kind == 1) begin
                vec_buf[i] = elem_t'($urandom_range(2**EW - 1, 2**(EW-1)));
            end else begin
                vec_buf[i] = elem_t'($urandom);
            end
        end
        if (kind == 2) begin
            vec_buf[0][EW-1] = 1'b0;
            vec_buf[1][EW-1] = 1'b1;
        end
    endtask

    // called and returns a step after a rising edge
    task automatic send_vec(input red_op_t op);
        int   gap;
        int   waited;
        logic took;
        exp_q.push_back(model_reduce(op));
        for (int b = 0; b < BEATS; b++) begin
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            repeat (gap) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_op    = op;
            for (int l = 0; l < LANES; l++) begin
                in_data[l*EW +: EW] = vec_buf[b*LANES + l];
            end
            waited = 0;
            took   = 1'b0;
            while (!took) begin
                @(negedge clk);
                took = in_ready;
                @(posedge clk);
                #1;
                waited++;
                if (!took && waited > TIMEOUT) begin
                    fail_run("timeout: the DUT never accepted an input beat");
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 4 * TIMEOUT) begin
                fail_run("timeout: outstanding vector results never arrived");
            end
        end
    endtask

    // switch back-pressure between edges
    task automatic set_ready_mode(input logic rnd);
        @(negedge clk);
        rand_ready = rnd;
        @(posedge clk);
        #1;
    endtask

    // ----------------------------------------
    // result side
    // ----------------------------------------

    task automatic run_monitor();
        int    idle;
        elem_t exp_e;
        idle = 0;
        forever begin
            @(posedge clk);
            #1;
            res_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
            @(negedge clk);
            if (res_valid && res_ready) begin
                idle = 0;
                if (exp_q.size() == 0) begin
                    fail_run("a result appeared with no vector outstanding");
                end
                exp_e = exp_q.pop_front();
                for (int l = 0; l < LANES; l++) begin
                    check_eq(res_data[l*EW +: EW], exp_e, $sformatf("result lane %0d", l));
                end
                got_q.push_back(res_data[EW-1:0]);
            end else if (exp_q.size() != 0) begin
                idle++;
                if (idle > TIMEOUT) begin
                    fail_run("timeout: no result within the limit while vectors are pending");
                end
            end else begin
                idle = 0;
            end
        end
    endtask

    initial begin : main
        int waited;
        void'($urandom(32'h873f45c5));
        in_valid   = 1'b0;
        in_op      = OP_UI_SUM;
        in_data    = '0;
        res_ready  = 1'b0;
        rand_ready = 1'b0;
        max_gap    = 0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("timeout: reset was never released");
            end
        end

        // idle state out of reset
        @(negedge clk);
        check_eq(res_valid, 1'b0, "res_valid after reset");
        check_eq(in_ready, 1'b1, "in_ready after reset");
        @(posedge clk);
        #1;
        fork
            run_monitor();
        join_none

        // wrapping unsigned sums
        for (int v = 0; v < 8; v++) begin
            fill_vec(1);
            send_vec(OP_UI_SUM);
        end
        wait_drain();

        // unsigned and signed max on the same data
        for (int v = 0; v < 4; v++) begin
            fill_vec(2);
            got_q.delete();
            send_vec(OP_UI_MAX);
            send_vec(OP_SI_MAX);
            wait_drain();
            check_eq(got_q[0] != got_q[1], 1'b1, "unsigned and signed max agree");
            check_eq(got_q[1][EW-1], 1'b0, "signed max is negative with a positive element");
        end

        // signed and unsigned sums match bit for bit
        for (int v = 0; v < 4; v++) begin
            fill_vec(0);
            got_q.delete();
            send_vec(OP_UI_SUM);
            send_vec(OP_SI_SUM);
            wait_drain();
            check_eq(got_q[1], got_q[0], "signed sum differs from unsigned sum");
        end

        // random ops with output back-pressure and input gaps
        set_ready_mode(1'b1);
        max_gap = 3;
        for (int v = 0; v < 40; v++) begin
            fill_vec(0);
            send_vec(red_op_t'($urandom_range(3, 0)));
        end
        wait_drain();

        // back to back with no stalls
        set_ready_mode(1'b0);
        max_gap = 0;
        for (int v = 0; v < 20; v++) begin
            fill_vec(0);
            send_vec(red_op_t'($urandom_range(3, 0)));
        end
        wait_drain();

        // no further result once the last vector is taken
        check_eq(res_valid, 1'b0, "result still valid after the last vector was taken");
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 2;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // reset low for a few edges, released just after an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* red_top.f */
+incdir+common
common/red_pkg.sv
common/red_beat_if.sv
red_tree/red_tree.sv
design/red_accum.sv
design/red_top.sv
dv/tb_clk_gen.sv
dv/red_tb.sv

/* red_tree/red_tree.sv */
`include "red_settings.svh"

module red_tree (
    input  logic                clk,
    input  logic                rst_n,

    // beat input
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  red_pkg::red_op_t    in_op_i,
    input  red_pkg::beat_data_t in_data_i,

    // one reduced element per beat
    red_beat_if.src             beat_o
);
    import red_pkg::*;

    localparam int N  = `RED_ELEMS_PER_BEAT;
    localparam int EW = `RED_ELEM_W;

    // global advance for the whole pipe
    logic                   adv;

    // per stage control, index 0 is nearest the input
    logic [TREE_LEVELS-1:0] stg_valid;
    red_op_t                stg_op [TREE_LEVELS];

    // final partial of the last stage
    elem_t                  root;

    // ----------------------------------------
    // stall control
    // ----------------------------------------

    // the pipe moves when the last stage is empty or hands its beat on
    // otherwise every stage freezes together
    assign adv        = !stg_valid[TREE_LEVELS-1] || beat_o.ready;
    assign in_ready_o = adv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stg_valid <= '0;
        end else if (adv) begin
            stg_valid[0] <= in_valid_i;
            for (int l = 1; l < TREE_LEVELS; l++) begin
                stg_valid[l] <= stg_valid[l-1];
            end
        end
    end

    // op travels alongside the partials
    always_ff @(posedge clk) begin
        if (adv) begin
            stg_op[0] <= in_op_i;
            for (int l = 1; l < TREE_LEVELS; l++) begin
                stg_op[l] <= stg_op[l-1];
            end
        end
    end

    // ----------------------------------------
    // pairwise levels
    // ----------------------------------------

    for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_lvl
        // results produced by this level
        localparam int W = N >> (l + 1);

        elem_t   src    [2*W];
        red_op_t src_op;
        elem_t   part_q [W];

        if (l == 0) begin : g_first
            // leaves come straight off the input beat
            for (genvar i = 0; i < 2*W; i++) begin : g_lane
                assign src[i] = in_data_i[i*EW +: EW];
            end
            assign src_op = in_op_i;
        end else begin : g_inner
            assign src    = g_lvl[l-1].part_q;
            assign src_op = stg_op[l-1];
        end

        // neighbours 2i and 2i+1 fold into slot i
        always_ff @(posedge clk) begin
            if (adv) begin
                for (int i = 0; i < W; i++) begin
                    part_q[i] <= red_combine(src_op, src[2*i], src[2*i+1]);
                end
            end
        end
    end

    assign root = g_lvl[TREE_LEVELS-1].part_q[0];

    // ----------------------------------------
    // output beat
    // ----------------------------------------

    assign beat_o.valid   = stg_valid[TREE_LEVELS-1];
    assign beat_o.op      = stg_op[TREE_LEVELS-1];
    assign beat_o.partial = root;

    // a waiting beat must not move until the accumulator takes it
    a_beat_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_o.valid && !beat_o.ready |=>
            beat_o.valid && $stable(beat_o.op) && $stable(beat_o.partial)
    ) else $error("red_tree: beat changed while waiting for ready");

endmodule
